// File: include/synapse_defines.svh
/* Core and supervisor sizing. Registers and data inputs are 16-bit words.
   The debug register and the last data input are fixed at index 15. */
`ifndef SYNAPSE_DEFINES_SVH
`define SYNAPSE_DEFINES_SVH

// Core register file size.
`define SYN_NUM_REGS 16

// Data inputs seen by the core. The top one is the break counter.
`define SYN_NUM_DATA_INPUTS 16

// Register reported at every break.
`define SYN_DEBUG_REG 15

// Avalon address of the first trace word.
`define SYN_TRACE_BASE 16'h0100

// Program ROM words. Addresses beyond this read as NOP.
`define SYN_ROM_DEPTH 256

`endif

// File: design/synapse_pkg.sv
/* Instruction set of the 16-bit core. Undefined opcodes execute as NOP. */
`default_nettype none

package synapse_pkg;

    typedef enum logic [3:0] {
        NOP = 4'd0,  // No operation.
        LDI = 4'd1,  // rd = zero-extended imm8.
        ADD = 4'd2,  // rd = rd + rs.
        MOV = 4'd3,  // rd = rs.
        IN  = 4'd4,  // rd = data input rs.
        BRK = 4'd5,  // Halt for the supervisor.
        JMP = 4'd6   // pc = imm8.
    } opcode_e;

    // Low byte is rs in its low nibble, or the full imm8.
    typedef struct packed {
        opcode_e    opcode;
        logic [3:0] rd;
        logic [7:0] arg;
    } instr_t;

endpackage

`default_nettype wire

// File: design/synapse_ifs.sv
/* Fetch and debug links between the core and its supervisor.
   Fetch completes when code_req and code_ready are both high on a rising edge. */
`timescale 1ns/1ps
`default_nettype none

interface code_fetch_if;
    logic [15:0] code_addr;
    logic        code_req;
    logic [15:0] code_in;
    logic        code_ready;

    modport core (
        output code_addr,
        output code_req,
        input  code_in,
        input  code_ready
    );

    modport supervisor (
        input  code_addr,
        input  code_req,
        output code_in,
        output code_ready
    );
endinterface

interface debug_if;
    logic        halted;       // Level, set by BRK.
    logic [15:0] break_value;  // Traced register.
    logic        resume;       // One-cycle pulse while halted.
    logic [15:0] break_count;

    modport core (
        output halted,
        output break_value,
        input  resume,
        input  break_count
    );

    modport supervisor (
        input  halted,
        input  break_value,
        output resume,
        output break_count
    );
endinterface

`default_nettype wire

// File: design/target_program.sv
/* Fixed trace program, answered combinationally.
   Loops forever and reads the break counter through data input 15. */
`timescale 1ns/1ps
`default_nettype none
`include "synapse_defines.svh"

module target_program (
    input  wire  [15:0] addr,
    output logic [15:0] data
);

    localparam int ROM_AW = $clog2(`SYN_ROM_DEPTH);

    function automatic synapse_pkg::instr_t word(
        input synapse_pkg::opcode_e op,
        input logic [3:0]           rd,
        input logic [7:0]           arg
    );
        synapse_pkg::instr_t w;
        w.opcode = op;
        w.rd     = rd;
        w.arg    = arg;
        return w;
    endfunction

    always_comb begin
        data = word(synapse_pkg::NOP, 4'd0, 8'd0);
        if (addr < `SYN_ROM_DEPTH) begin
            case (addr[ROM_AW-1:0])
                8'd0: data = word(synapse_pkg::IN,  4'd1,  8'd0);   // r1 = in0.
                8'd1: data = word(synapse_pkg::IN,  4'd2,  8'd1);   // r2 = in1.
                8'd2: data = word(synapse_pkg::ADD, 4'd1,  8'd2);
                8'd3: data = word(synapse_pkg::IN,  4'd3,  8'd15);  // Break count.
                8'd4: data = word(synapse_pkg::ADD, 4'd1,  8'd3);
                8'd5: data = word(synapse_pkg::MOV, 4'd15, 8'd1);   // Publish sum.
                8'd6: data = word(synapse_pkg::BRK, 4'd0,  8'd0);
                8'd7: data = word(synapse_pkg::JMP, 4'd0,  8'd0);
                default: data = word(synapse_pkg::NOP, 4'd0, 8'd0);
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/synapse_core.sv
/* Single-issue core that executes each instruction on the edge that accepts it.
   After BRK it stops fetching until the supervisor pulses resume. */
`timescale 1ns/1ps
`default_nettype none
`include "synapse_defines.svh"

module synapse_core (
    input  wire                                  sysclk,
    input  wire                                  rst_n,
    input  wire  [`SYN_NUM_DATA_INPUTS*16-1:0]   data_in_flat,
    code_fetch_if.core                           fetch,
    debug_if.core                                dbg,
    output logic [`SYN_NUM_REGS*16-1:0]          r_flat,
    output logic [`SYN_NUM_REGS-1:0]             r_load
);

    localparam int REG_AW = $clog2(`SYN_NUM_REGS);

    logic [15:0]         regs [`SYN_NUM_REGS];
    logic [15:0]         pc;
    logic                halted;
    synapse_pkg::instr_t instr;
    logic [3:0]          rs;
    logic                accept;

    // Decode results, applied only on an accepted fetch.
    logic                wr_en;
    logic [REG_AW-1:0]   wr_idx;
    logic [15:0]         wr_data;
    logic [15:0]         pc_next;
    logic                is_brk;

    assign instr  = fetch.code_in;
    assign rs     = instr.arg[3:0];
    assign accept = fetch.code_req && fetch.code_ready;

    assign fetch.code_addr = pc;
    assign fetch.code_req  = !halted;  // No fetch while stopped.

    assign dbg.halted      = halted;
    assign dbg.break_value = regs[`SYN_DEBUG_REG];

    always_comb begin
        wr_en   = 1'b0;
        wr_idx  = instr.rd;
        wr_data = 16'h0000;
        pc_next = pc + 16'd1;
        is_brk  = 1'b0;
        case (instr.opcode)
            synapse_pkg::LDI: begin
                wr_en   = 1'b1;
                wr_data = {8'h00, instr.arg};
            end
            synapse_pkg::ADD: begin
                wr_en   = 1'b1;
                wr_data = regs[instr.rd] + regs[rs];  // Wraps modulo 2^16.
            end
            synapse_pkg::MOV: begin
                wr_en   = 1'b1;
                wr_data = regs[rs];
            end
            synapse_pkg::IN: begin
                wr_en   = 1'b1;
                wr_data = data_in_flat[rs*16 +: 16];
            end
            synapse_pkg::BRK: begin
                is_brk = 1'b1;
            end
            synapse_pkg::JMP: begin
                pc_next = {8'h00, instr.arg};
            end
            default: begin
                // NOP and unused codes only advance the PC.
            end
        endcase
    end

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= 16'h0000;
            halted <= 1'b0;
            r_load <= '0;
            for (int i = 0; i < `SYN_NUM_REGS; i++) begin
                regs[i] <= 16'h0000;
            end
        end else begin
            r_load <= '0;  // Load strobes last one cycle.
            if (accept) begin
                pc <= pc_next;
                if (is_brk) begin
                    halted <= 1'b1;
                end
                if (wr_en) begin
                    regs[wr_idx]   <= wr_data;
                    r_load[wr_idx] <= 1'b1;
                end
            end else if (dbg.resume) begin
                halted <= 1'b0;  // Fetch restarts next cycle.
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `SYN_NUM_REGS; i++) begin
            r_flat[i*16 +: 16] = regs[i];
        end
    end

endmodule

`default_nettype wire

// File: design/visor.sv
/* Debug supervisor in series with the fetch path. One Avalon write per break,
   the core stays halted until that write is accepted. */
`timescale 1ns/1ps
`default_nettype none
`include "synapse_defines.svh"

module visor (
    input  wire         sysclk,
    input  wire         rst_n,
    input  wire  [15:0] rom_code_in,
    input  wire         dbg_av_waitrequest,
    code_fetch_if.supervisor fetch,
    debug_if.supervisor      dbg,
    output logic [15:0] rom_addr,
    output logic [15:0] dbg_av_address,
    output logic [15:0] dbg_av_writedata,
    output logic        dbg_av_write
);

    typedef enum logic {
        ST_IDLE,
        ST_WRITE
    } wr_state_e;

    wr_state_e   state;
    logic        halted_q;
    logic        halted_rise;
    logic        resume_q;
    logic [15:0] count;

    // Fetch path. The ROM answers in the same cycle.
    assign rom_addr         = fetch.code_addr;
    assign fetch.code_in    = rom_code_in;
    assign fetch.code_ready = fetch.code_req && !dbg.halted;

    assign halted_rise     = dbg.halted && !halted_q;
    assign dbg.resume      = resume_q;
    assign dbg.break_count = count;
    assign dbg_av_write    = (state == ST_WRITE);

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            halted_q <= 1'b0;
            resume_q <= 1'b0;
            count    <= 16'h0000;
        end else begin
            halted_q <= dbg.halted;
            resume_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (halted_rise) begin
                        state <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    if (!dbg_av_waitrequest) begin  // Write accepted.
                        state    <= ST_IDLE;
                        count    <= count + 16'd1;
                        resume_q <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Address and data held stable for the whole write.
    always_ff @(posedge sysclk) begin
        if (state == ST_IDLE && halted_rise) begin
            dbg_av_address   <= `SYN_TRACE_BASE + count;
            dbg_av_writedata <= dbg.break_value;
        end
    end

endmodule

`default_nettype wire

// File: design/supervised_synapse.sv
/* Core, program ROM and debug supervisor. Data input 15 of the core is the
   break counter, so data_in_flat carries inputs 0 to 14 only. */
`timescale 1ns/1ps
`default_nettype none
`include "synapse_defines.svh"

module supervised_synapse (
    input  wire                                    sysclk,
    input  wire                                    rst_n,
    input  wire [(`SYN_NUM_DATA_INPUTS-1)*16-1:0]  data_in_flat,
    input  wire                                    dbg_av_waitrequest,
    output wire [`SYN_NUM_REGS*16-1:0]             r_flat,
    output wire [`SYN_NUM_REGS-1:0]                r_load,
    output wire [15:0]                             dbg_av_address,
    output wire [15:0]                             dbg_av_writedata,
    output wire                                    dbg_av_write
);

    wire [15:0] rom_addr;
    wire [15:0] rom_code_in;

    code_fetch_if fetch_bus ();
    debug_if      debug_bus ();

    target_program rom (
        .addr (rom_addr),
        .data (rom_code_in)
    );

    visor visr (
        .sysclk             (sysclk),
        .rst_n              (rst_n),
        .rom_code_in        (rom_code_in),
        .dbg_av_waitrequest (dbg_av_waitrequest),
        .fetch              (fetch_bus.supervisor),
        .dbg                (debug_bus.supervisor),
        .rom_addr           (rom_addr),
        .dbg_av_address     (dbg_av_address),
        .dbg_av_writedata   (dbg_av_writedata),
        .dbg_av_write       (dbg_av_write)
    );

    synapse_core target (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .data_in_flat ({debug_bus.break_count, data_in_flat}),  // Counter on top.
        .fetch        (fetch_bus.core),
        .dbg          (debug_bus.core),
        .r_flat       (r_flat),
        .r_load       (r_load)
    );

endmodule

`default_nettype wire

// File: verification/supervised_synapse_assert.sv
/* Protocol checks on the Avalon trace port and the register load strobes.
   Bound to every supervised_synapse instance. */
`timescale 1ns/1ps
`default_nettype none
`include "synapse_defines.svh"

module supervised_synapse_assert (
    input wire                      sysclk,
    input wire                      rst_n,
    input wire                      dbg_av_waitrequest,
    input wire                      dbg_av_write,
    input wire [15:0]               dbg_av_address,
    input wire [15:0]               dbg_av_writedata,
    input wire [`SYN_NUM_REGS-1:0]  r_load
);

    int assert_fails = 0;  // Failed assertion count.

    property write_held;
        @(posedge sysclk) disable iff (!rst_n)
            dbg_av_write && dbg_av_waitrequest |=>
                dbg_av_write && $stable(dbg_av_address) && $stable(dbg_av_writedata);
    endproperty

    property load_onehot;
        @(posedge sysclk) disable iff (!rst_n) $onehot0(r_load);
    endproperty

    property no_write_in_reset;
        @(posedge sysclk) !rst_n |-> !dbg_av_write;
    endproperty

    assert property (write_held) else begin
        assert_fails = assert_fails + 1;
        $error("Avalon write changed while waitrequest was high.");
    end

    assert property (load_onehot) else begin
        assert_fails = assert_fails + 1;
        $error("More than one r_load bit set.");
    end

    assert property (no_write_in_reset) else begin
        assert_fails = assert_fails + 1;
        $error("dbg_av_write high during reset.");
    end

endmodule

bind supervised_synapse supervised_synapse_assert sva (
    .sysclk             (sysclk),
    .rst_n              (rst_n),
    .dbg_av_waitrequest (dbg_av_waitrequest),
    .dbg_av_write       (dbg_av_write),
    .dbg_av_address     (dbg_av_address),
    .dbg_av_writedata   (dbg_av_writedata),
    .r_load             (r_load)
);

`default_nettype wire

// File: verification/tb_supervised_synapse.sv
/* Runs the trace program over table rows with varied Avalon back-pressure.
   Row data reaches the core while the previous trace write is still held. */
`timescale 1ns/1ps
`default_nettype none
`include "synapse_defines.svh"

module tb_supervised_synapse;

    localparam int NUM_ROWS      = 10;
    localparam int WRITE_TIMEOUT = 100;  // Cycles allowed per program loop.

    typedef struct packed {
        logic [15:0] in0;
        logic [15:0] in1;
        logic [3:0]  hold;       // Waitrequest cycles before release.
        logic        do_reset;   // Reset the DUT before this row.
        logic [3:0]  trace_idx;  // Expected break count.
    } row_t;

    logic                                    sysclk;
    logic                                    rst_n;
    logic [(`SYN_NUM_DATA_INPUTS-1)*16-1:0]  data_in_flat;
    logic                                    dbg_av_waitrequest;
    wire  [`SYN_NUM_REGS*16-1:0]             r_flat;
    wire  [`SYN_NUM_REGS-1:0]                r_load;
    wire  [15:0]                             dbg_av_address;
    wire  [15:0]                             dbg_av_writedata;
    wire                                     dbg_av_write;

    row_t        rows [NUM_ROWS];
    logic [31:0] lcg_state;
    int          errors;
    int          r15_loads;
    bit          timed_out;

    supervised_synapse UUT (
        .sysclk             (sysclk),
        .rst_n              (rst_n),
        .data_in_flat       (data_in_flat),
        .dbg_av_waitrequest (dbg_av_waitrequest),
        .r_flat             (r_flat),
        .r_load             (r_load),
        .dbg_av_address     (dbg_av_address),
        .dbg_av_writedata   (dbg_av_writedata),
        .dbg_av_write       (dbg_av_write)
    );

    always #5 sysclk = ~sysclk;

    always @(negedge sysclk) begin
        if (r_load[15]) begin
            r15_loads = r15_loads + 1;  // Loads since the last trace write.
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic row_t make_row(
        input logic [15:0] in0,
        input logic [15:0] in1,
        input int          hold,
        input logic        do_reset,
        input int          idx
    );
        row_t row;
        row.in0       = in0;
        row.in1       = in1;
        row.hold      = 4'(hold);
        row.do_reset  = do_reset;
        row.trace_idx = 4'(idx);
        return row;
    endfunction

    task automatic draw_pair(output logic [15:0] a, output logic [15:0] b);
        lcg_state = lcg_next(lcg_state);
        a = lcg_state[31:16];
        lcg_state = lcg_next(lcg_state);
        b = lcg_state[31:16];
    endtask

    task automatic build_table();
        logic [15:0] a;
        logic [15:0] b;
        rows[0] = make_row(16'h0001, 16'h0002, 0, 1'b1, 0);
        rows[1] = make_row(16'h1234, 16'h4321, 3, 1'b0, 1);
        rows[2] = make_row(16'hFFFF, 16'h0001, 1, 1'b0, 2);  // Sum wraps.
        draw_pair(a, b);
        rows[3] = make_row(a, b, 5, 1'b0, 3);
        draw_pair(a, b);
        rows[4] = make_row(a, b, 0, 1'b0, 4);
        rows[5] = make_row(16'h8000, 16'h8000, 2, 1'b1, 0);  // Count restarts.
        draw_pair(a, b);
        rows[6] = make_row(a, b, 4, 1'b0, 1);
        draw_pair(a, b);
        rows[7] = make_row(a, b, 0, 1'b0, 2);
        rows[8] = make_row(16'hFFF0, 16'h000C, 7, 1'b0, 3);
        draw_pair(a, b);
        rows[9] = make_row(a, b, 1, 1'b0, 4);
    endtask

    task automatic apply_inputs(input logic [15:0] in0, input logic [15:0] in1);
        for (int i = 2; i < `SYN_NUM_DATA_INPUTS - 1; i++) begin
            data_in_flat[i*16 +: 16] = 16'hA500 + 16'(i);  // Unread by the program.
        end
        data_in_flat[15:0]  = in0;
        data_in_flat[31:16] = in1;
    endtask

    task automatic report_mismatch(
        input string       name,
        input int          r,
        input logic [15:0] exp,
        input logic [15:0] act
    );
        $display("[ERROR] %s row %0d: expected 0x%04h, actual 0x%04h", name, r, exp, act);
        errors = errors + 1;
    endtask

    task automatic apply_reset(input logic [15:0] in0, input logic [15:0] in1);
        @(posedge sysclk);
        #1;
        rst_n              = 1'b0;
        dbg_av_waitrequest = 1'b1;
        apply_inputs(in0, in1);
        repeat (2) @(posedge sysclk);
        #1;
        if (dbg_av_write !== 1'b0) begin
            $display("[ERROR] dbg_av_write is high during reset");
            errors = errors + 1;
        end
        if (r_load !== '0) begin
            $display("[ERROR] r_load is not zero during reset");
            errors = errors + 1;
        end
        rst_n     = 1'b1;
        r15_loads = 0;
    endtask

    task automatic wait_for_write(output bit seen);
        int cycles;
        cycles = 0;
        while (dbg_av_write !== 1'b1 && cycles < WRITE_TIMEOUT) begin
            @(posedge sysclk);
            #1;
            cycles = cycles + 1;
        end
        seen = (dbg_av_write === 1'b1);
    endtask

    task automatic release_write(
        input int          r,
        input int          hold,
        input logic [15:0] exp_addr,
        input logic [15:0] exp_data
    );
        for (int c = 0; c < hold; c++) begin
            @(posedge sysclk);
            #1;
            if (dbg_av_write !== 1'b1) begin
                $display("[ERROR] row %0d: write dropped while waitrequest was high", r);
                errors = errors + 1;
            end
            if (dbg_av_address !== exp_addr) begin
                report_mismatch("held_address", r, exp_addr, dbg_av_address);
            end
            if (dbg_av_writedata !== exp_data) begin
                report_mismatch("held_data", r, exp_data, dbg_av_writedata);
            end
        end
        dbg_av_waitrequest = 1'b0;
        @(posedge sysclk);
        #1;
        dbg_av_waitrequest = 1'b1;
        if (dbg_av_write !== 1'b0) begin
            $display("[ERROR] row %0d: write still high after it was accepted", r);
            errors = errors + 1;
        end
    endtask

    initial begin : run_rows
        int          r;
        int          errs_before;
        bit          seen;
        logic [15:0] exp_data;
        logic [15:0] exp_addr;
        sysclk             = 1'b0;
        rst_n              = 1'b0;
        dbg_av_waitrequest = 1'b1;
        data_in_flat       = '0;
        errors             = 0;
        r15_loads          = 0;
        timed_out          = 1'b0;
        lcg_state          = 32'h07757932;
        build_table();
        apply_inputs(rows[0].in0, rows[0].in1);
        for (r = 0; r < NUM_ROWS && !timed_out; r++) begin
            errs_before = errors;
            exp_data    = rows[r].in0 + rows[r].in1 + 16'(rows[r].trace_idx);
            exp_addr    = `SYN_TRACE_BASE + 16'(rows[r].trace_idx);
            if (rows[r].do_reset) begin
                apply_reset(rows[r].in0, rows[r].in1);
            end
            wait_for_write(seen);
            if (!seen) begin
                $display("[ERROR] row %0d: no trace write within %0d cycles", r, WRITE_TIMEOUT);
                timed_out = 1'b1;
            end else begin
                if (dbg_av_writedata !== exp_data) begin
                    report_mismatch("trace_data", r, exp_data, dbg_av_writedata);
                end
                if (dbg_av_address !== exp_addr) begin
                    report_mismatch("trace_address", r, exp_addr, dbg_av_address);
                end
                if (r_flat[15*16 +: 16] !== exp_data) begin
                    report_mismatch("r15_value", r, exp_data, r_flat[15*16 +: 16]);
                end
                if (r_flat[3*16 +: 16] !== 16'(rows[r].trace_idx)) begin
                    report_mismatch("r3_count", r, 16'(rows[r].trace_idx), r_flat[3*16 +: 16]);
                end
                if (r15_loads != 1) begin
                    report_mismatch("r15_loads", r, 16'd1, 16'(r15_loads));
                end
                r15_loads = 0;
                if (r + 1 < NUM_ROWS) begin
                    apply_inputs(rows[r+1].in0, rows[r+1].in1);  // Read after resume.
                end
                release_write(r, rows[r].hold, exp_addr, exp_data);
                $display("row %0d: trace 0x%04h data 0x%04h hold %0d, %s", r, exp_addr,
                         exp_data, rows[r].hold, (errors == errs_before) ? "ok" : "mismatch");
            end
        end
        $display("summary: %0d of %0d rows run, %0d errors, %0d assertion failures",
                 r, NUM_ROWS, errors, UUT.sva.assert_fails);
        if (errors == 0 && !timed_out && UUT.sva.assert_fails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: supervised_synapse.f
+incdir+include
design/synapse_pkg.sv
design/synapse_ifs.sv
design/target_program.sv
design/synapse_core.sv
design/visor.sv
design/supervised_synapse.sv
verification/supervised_synapse_assert.sv
verification/tb_supervised_synapse.sv
